// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       := etx_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the pass line in the simulator output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/etx_tb.sv ====
`default_nettype none

module etx_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import etx_pkg::*;

   localparam int period_c     = 8;                          // Clock period in ns
   localparam int run_cycles_c = 20 + 30 + 80 + 120 + 150 + 40; // Test lengths added up

   logic        clk = 1'b0;
   logic        arst_n;
   logic        emwr_wr_en;
   logic        emrq_wr_en;
   logic        emrr_wr_en;
   emesh_t      emwr_wr_data;
   emesh_t      emrq_wr_data;
   emesh_t      emrr_wr_data;
   logic        emwr_full;
   logic        emwr_prog_full;
   logic        emrq_full;
   logic        emrq_prog_full;
   logic        emrr_full;
   logic        emrr_prog_full;
   logic        wr_wait_in;
   logic        rd_wait_in;
   logic        ecfg_tx_enable;
   logic        ecfg_tx_gpio_enable;
   logic [8:0]  ecfg_dataout;
   logic [7:0]  tx_frame_par;
   logic [63:0] tx_data_par;
   logic [1:0]  ecfg_tx_datain;

   emesh_t      mq_rr[$];                  // In a DUT queue, not granted yet
   emesh_t      mq_wr[$];
   emesh_t      mq_rq[$];
   emesh_t      exp_mem [64];              // Granted packets in line order
   logic [5:0]  exp_wr;                    // Next free slot
   logic [5:0]  exp_rd;                    // Packet due on the line
   emesh_t      exp_cur;
   logic [63:0] exp_hdr;
   logic [63:0] exp_pay;
   beat_u       obs;                       // Line beat seen through the union
   logic        beat_phase;                // Payload beat due
   logic        wr_blk;                    // Model view of the waits
   logic        rd_blk;
   logic [1:0]  wait_d1;                   // Wait inputs, one and two edges back
   logic [1:0]  wait_d2;
   logic        en_d;                      // Settings one edge back
   logic        gpio_d;
   logic [8:0]  dout_d;
   logic [7:0]  ovr_frame;
   logic [63:0] ovr_data;
   logic        chk_en;                    // Beat checks on
   logic        rst_chk;
   logic        no_wr_class;               // Write class must stay off the line
   logic        flag_chk;
   logic        ovr_chk;
   int          flag_cnt;                  // Model occupancy of the write queue
   int          err_cnt;
   int          bad_tests;
   int          tests_run;

   etx dut_i (.tx_lclk_par(clk), .*);

   always #(period_c / 2) clk = ~clk;

   always @(posedge clk)
   begin
      wait_d1 <= {wr_wait_in, rd_wait_in};
      wait_d2 <= wait_d1;
      en_d    <= ecfg_tx_enable;
      gpio_d  <= ecfg_tx_gpio_enable;
      dout_d  <= ecfg_dataout;
      if (!flag_chk)
         flag_cnt <= 0;
      else if (emwr_wr_en && flag_cnt < queue_depth_c)
         flag_cnt <= flag_cnt + 1;         // Write while full is lost
      if (!arst_n)
      begin
         beat_phase <= 1'b0;
         exp_rd     <= '0;
      end
      else if (chk_en)
      begin
         if (!beat_phase && tx_frame_par != 8'h00)
            beat_phase <= 1'b1;            // Header seen
         else if (beat_phase)
         begin
            beat_phase <= 1'b0;
            exp_rd     <= exp_rd + 1'b1;   // Packet retired
         end
      end
   end

   assign exp_cur   = exp_mem[exp_rd];
   // Ctrl byte, reserved zeros, then address
   assign exp_hdr   = {exp_cur.ctrlmode, exp_cur.datamode, exp_cur.write, 1'b0,
                       24'h000000, exp_cur.dstaddr};
   assign exp_pay   = {exp_cur.data, exp_cur.srcaddr};
   assign obs       = tx_data_par;
   assign ovr_frame = (en_d && gpio_d) ? {8{dout_d[8]}} : 8'h00;      // Idle line otherwise
   assign ovr_data  = (en_d && gpio_d) ? {8{dout_d[7:0]}} : 64'h0;

   task automatic mismatch(input string sig, input logic [63:0] exp_v,
                           input logic [63:0] got_v);
      err_cnt++;
      $display("[FAIL] %s expected %0h got %0h at %0t", sig, exp_v, got_v, $time);
   endtask

   task automatic problem(input string msg);
      err_cnt++;
      $display("Error at %0t: %s", $time, msg);
   endtask

   a_pkt_expected: assert property (@(posedge clk) disable iff (!arst_n)
      chk_en && !beat_phase && tx_frame_par != 8'h00 |-> exp_rd != exp_wr)
      else problem("a packet appeared on the line while none was expected");
   a_hdr_frame: assert property (@(posedge clk) disable iff (!arst_n)
      chk_en && !beat_phase && tx_frame_par != 8'h00 |-> tx_frame_par == 8'hff)
      else mismatch("tx_frame_par", 64'hff, $sampled(tx_frame_par));
   a_hdr_data: assert property (@(posedge clk) disable iff (!arst_n)
      chk_en && !beat_phase && tx_frame_par != 8'h00 && exp_rd != exp_wr
      |-> tx_data_par == exp_hdr)
      else mismatch("tx_data_par", $sampled(exp_hdr), $sampled(tx_data_par));
   a_pay_frame: assert property (@(posedge clk) disable iff (!arst_n)
      chk_en && beat_phase |-> tx_frame_par == 8'hff)      // Second beat follows at once
      else mismatch("tx_frame_par", 64'hff, $sampled(tx_frame_par));
   a_pay_data: assert property (@(posedge clk) disable iff (!arst_n)
      chk_en && beat_phase |-> tx_data_par == exp_pay)
      else mismatch("tx_data_par", $sampled(exp_pay), $sampled(tx_data_par));
   a_wr_held: assert property (@(posedge clk) disable iff (!arst_n)
      no_wr_class && !beat_phase && tx_frame_par != 8'h00 |-> !obs.hdr.write)
      else problem("a write-class packet was sent while wr_wait was held");
   a_wait_status: assert property (@(posedge clk) disable iff (!arst_n)
      ecfg_tx_datain == wait_d2)           // Two-flop sync delay
      else mismatch("ecfg_tx_datain", $sampled(wait_d2), $sampled(ecfg_tx_datain));
   a_reset_frame: assert property (@(posedge clk) disable iff (!arst_n)
      rst_chk |-> tx_frame_par == 8'h00)
      else mismatch("tx_frame_par", 64'h0, $sampled(tx_frame_par));
   a_reset_data: assert property (@(posedge clk) disable iff (!arst_n)
      rst_chk |-> tx_data_par == 64'h0)
      else mismatch("tx_data_par", 64'h0, $sampled(tx_data_par));
   a_reset_flags: assert property (@(posedge clk) disable iff (!arst_n)
      rst_chk |-> {emwr_full, emrq_full, emrr_full,
                   emwr_prog_full, emrq_prog_full, emrr_prog_full} == 6'b000000)
      else mismatch("full and prog_full flags", 64'h0,
                    $sampled({emwr_full, emrq_full, emrr_full,
                              emwr_prog_full, emrq_prog_full, emrr_prog_full}));
   a_flags: assert property (@(posedge clk) disable iff (!arst_n)
      flag_chk |-> {emwr_full, emwr_prog_full} ==
      {flag_cnt >= queue_depth_c, flag_cnt >= queue_depth_c - prog_margin_c})
      else mismatch("{emwr_full,emwr_prog_full}",
                    $sampled({flag_cnt >= queue_depth_c,
                              flag_cnt >= queue_depth_c - prog_margin_c}),
                    $sampled({emwr_full, emwr_prog_full}));
   a_ovr_frame: assert property (@(posedge clk) disable iff (!arst_n)
      ovr_chk |-> tx_frame_par == ovr_frame)
      else mismatch("tx_frame_par", $sampled(ovr_frame), $sampled(tx_frame_par));
   a_ovr_data: assert property (@(posedge clk) disable iff (!arst_n)
      ovr_chk |-> tx_data_par == ovr_data)
      else mismatch("tx_data_par", $sampled(ovr_data), $sampled(tx_data_par));

   function automatic emesh_t make_trans(input logic wr);
      emesh_t t;
      t.access   = 1'b1;
      t.write    = wr;                     // Writes and responses carry 1
      t.datamode = 2'($urandom);
      t.ctrlmode = 4'($urandom);
      t.dstaddr  = $urandom;
      t.data     = $urandom;
      t.srcaddr  = $urandom;
      return t;
   endfunction

   // Moves eligible entries to the expected list, response over write over request
   task automatic grant_model();
      emesh_t t;
      logic   more;
      more = 1'b1;
      while (more)
      begin
         if (!wr_blk && mq_rr.size() > 0)
            t = mq_rr.pop_front();
         else if (!wr_blk && mq_wr.size() > 0)
            t = mq_wr.pop_front();
         else if (!rd_blk && mq_rq.size() > 0)
            t = mq_rq.pop_front();
         else
            more = 1'b0;
         if (more)
         begin
            exp_mem[exp_wr] = t;
            exp_wr          = exp_wr + 1'b1;
         end
      end
   endtask

   // Class 0 response, 1 write, 2 read request; starts and ends on a falling edge
   task automatic push_trans(input int cls, input emesh_t t);
      if (cls == 0)
      begin
         emrr_wr_en   = 1'b1;
         emrr_wr_data = t;
         if (mq_rr.size() < queue_depth_c)
            mq_rr.push_back(t);
      end
      else if (cls == 1)
      begin
         emwr_wr_en   = 1'b1;
         emwr_wr_data = t;
         if (mq_wr.size() < queue_depth_c)
            mq_wr.push_back(t);            // Dropped when the queue is full
      end
      else
      begin
         emrq_wr_en   = 1'b1;
         emrq_wr_data = t;
         if (mq_rq.size() < queue_depth_c)
            mq_rq.push_back(t);
      end
      grant_model();
      @(negedge clk);
      emrr_wr_en = 1'b0;
      emwr_wr_en = 1'b0;
      emrq_wr_en = 1'b0;
   endtask

   task automatic set_waits(input logic w, input logic r);
      wr_wait_in = w;
      rd_wait_in = r;
      wr_blk     = w;
      rd_blk     = r;
      grant_model();                       // Release lets held entries go
   endtask

   // Waits until every granted packet has left, then a quiet gap
   task automatic wait_drain(input int max_cycles);
      int n;
      n = 0;
      while (exp_rd != exp_wr && n < max_cycles)
      begin
         @(negedge clk);
         n++;
      end
      if (exp_rd != exp_wr)
         problem("expected packets did not all appear on the line");
      repeat (8) @(negedge clk);           // Extra packets would show here
   endtask

   task automatic finish_test(input string name, input int mark);
      tests_run++;
      if (err_cnt == mark)
         $display("Test %-13s done, no errors", name);
      else
      begin
         bad_tests++;
         $display("Test %-13s done, %0d errors", name, err_cnt - mark);
      end
   endtask

   initial
   begin
      #(2 * run_cycles_c * period_c);
      $display("Watchdog expired before the tests finished");
      $display("Simulation FAILED");
      $finish;
   end

   initial
   begin
      int err_mark;
      int i;
      arst_n              = 1'b0;
      emwr_wr_en          = 1'b0;
      emrq_wr_en          = 1'b0;
      emrr_wr_en          = 1'b0;
      emwr_wr_data        = '0;
      emrq_wr_data        = '0;
      emrr_wr_data        = '0;
      wr_wait_in          = 1'b0;
      rd_wait_in          = 1'b0;
      ecfg_tx_enable      = 1'b1;
      ecfg_tx_gpio_enable = 1'b0;
      ecfg_dataout        = '0;
      wr_blk              = 1'b0;
      rd_blk              = 1'b0;
      exp_wr              = '0;
      chk_en              = 1'b1;
      rst_chk             = 1'b0;
      no_wr_class         = 1'b0;
      flag_chk            = 1'b0;
      ovr_chk             = 1'b0;
      err_cnt             = 0;
      bad_tests           = 0;
      tests_run           = 0;
      void'($urandom(32'h200d_ae3c));
      repeat (3) @(negedge clk);
      arst_n = 1'b1;

      err_mark = err_cnt;                  // Reset values and idle line
      rst_chk  = 1'b1;
      repeat (12) @(negedge clk);
      rst_chk = 1'b0;
      finish_test("reset_idle", err_mark);

      err_mark = err_cnt;
      push_trans(1, make_trans(1'b1));
      wait_drain(30);
      finish_test("single_write", err_mark);

      err_mark = err_cnt;                  // Load all classes behind both waits
      set_waits(1'b1, 1'b1);
      repeat (3) @(negedge clk);
      for (i = 0; i < 3; i++)
      begin
         push_trans(2, make_trans(1'b0));
         push_trans(1, make_trans(1'b1));
         push_trans(0, make_trans(1'b1));
      end
      set_waits(1'b0, 1'b0);
      wait_drain(80);
      finish_test("priority", err_mark);

      err_mark = err_cnt;
      set_waits(1'b1, 1'b0);
      repeat (3) @(negedge clk);           // Sync delay
      no_wr_class = 1'b1;
      for (i = 0; i < 4; i++)
      begin
         push_trans(1, make_trans(1'b1));
         push_trans(2, make_trans(1'b0));
      end
      wait_drain(60);                      // Reads only
      no_wr_class = 1'b0;
      set_waits(1'b0, 1'b0);
      wait_drain(60);
      finish_test("backpressure", err_mark);

      err_mark = err_cnt;
      set_waits(1'b1, 1'b1);
      repeat (3) @(negedge clk);
      flag_chk = 1'b1;
      for (i = 0; i <= queue_depth_c; i++)
         push_trans(1, make_trans(1'b1));  // Last one finds the queue full
      repeat (2) @(negedge clk);
      flag_chk = 1'b0;
      set_waits(1'b0, 1'b0);
      wait_drain(100);
      finish_test("queue_flags", err_mark);

      err_mark = err_cnt;
      chk_en   = 1'b0;                     // Pattern frames are not packets
      ovr_chk  = 1'b1;
      for (i = 0; i < 12; i++)
      begin
         ecfg_tx_enable      = (i >= 2);
         ecfg_tx_gpio_enable = ((i % 2) == 1);
         ecfg_dataout        = 9'($urandom);
         @(negedge clk);
      end
      ecfg_tx_enable      = 1'b1;
      ecfg_tx_gpio_enable = 1'b0;
      repeat (3) @(negedge clk);
      ovr_chk = 1'b0;
      finish_test("overrides", err_mark);

      $display("Tests run %0d, tests with errors %0d, total errors %0d",
               tests_run, bad_tests, err_cnt);
      if (err_cnt == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/etx.sv ====
`default_nettype none

module etx (
   input  wire             tx_lclk_par,
   input  wire             arst_n,
   // Write requests
   input  wire             emwr_wr_en,
   input  etx_pkg::emesh_t emwr_wr_data,
   output logic            emwr_full,
   output logic            emwr_prog_full,
   // Read requests
   input  wire             emrq_wr_en,
   input  etx_pkg::emesh_t emrq_wr_data,
   output logic            emrq_full,
   output logic            emrq_prog_full,
   // Read responses
   input  wire             emrr_wr_en,
   input  etx_pkg::emesh_t emrr_wr_data,
   output logic            emrr_full,
   output logic            emrr_prog_full,
   // Push-back from the far end, asynchronous
   input  wire             wr_wait_in,
   input  wire             rd_wait_in,
   // Configuration
   input  wire             ecfg_tx_enable,
   input  wire             ecfg_tx_gpio_enable,
   input  wire [8:0]       ecfg_dataout,
   // Line side
   output logic [7:0]      tx_frame_par,
   output logic [63:0]     tx_data_par,
   output logic [1:0]      ecfg_tx_datain
);
   import etx_pkg::*;

   emesh_t     emwr_head;                  // Queue heads
   emesh_t     emrq_head;
   emesh_t     emrr_head;
   logic       emwr_empty;
   logic       emrq_empty;
   logic       emrr_empty;
   logic       emwr_rd_en;                 // Pops from the arbiter
   logic       emrq_rd_en;
   logic       emrr_rd_en;
   logic       tx_access;
   emesh_t     tx_trans;
   logic       tx_ack;
   logic [7:0] frame_par;                  // Formatter to output stage
   beat_u      data_par;
   logic       wr_wait;                    // Synchronized waits
   logic       rd_wait;

   etx_fifo #(.DEPTH(queue_depth_c)) s_wr_fifo (
      .clk(tx_lclk_par), .arst_n(arst_n),
      .wr_en(emwr_wr_en), .wr_data(emwr_wr_data),
      .rd_en(emwr_rd_en), .rd_data(emwr_head),
      .empty(emwr_empty), .full(emwr_full), .prog_full(emwr_prog_full)
   );

   etx_fifo #(.DEPTH(queue_depth_c)) s_rq_fifo (
      .clk(tx_lclk_par), .arst_n(arst_n),
      .wr_en(emrq_wr_en), .wr_data(emrq_wr_data),
      .rd_en(emrq_rd_en), .rd_data(emrq_head),
      .empty(emrq_empty), .full(emrq_full), .prog_full(emrq_prog_full)
   );

   etx_fifo #(.DEPTH(queue_depth_c)) m_rr_fifo (
      .clk(tx_lclk_par), .arst_n(arst_n),
      .wr_en(emrr_wr_en), .wr_data(emrr_wr_data),
      .rd_en(emrr_rd_en), .rd_data(emrr_head),
      .empty(emrr_empty), .full(emrr_full), .prog_full(emrr_prog_full)
   );

   etx_arbiter etx_arbiter_i (
      .tx_lclk_par(tx_lclk_par), .arst_n(arst_n),
      .emwr_head(emwr_head), .emrq_head(emrq_head), .emrr_head(emrr_head),
      .emwr_empty(emwr_empty), .emrq_empty(emrq_empty), .emrr_empty(emrr_empty),
      .emwr_rd_en(emwr_rd_en), .emrq_rd_en(emrq_rd_en), .emrr_rd_en(emrr_rd_en),
      .wr_wait(wr_wait), .rd_wait(rd_wait),
      .tx_access(tx_access), .tx_trans(tx_trans), .tx_ack(tx_ack)
   );

   etx_protocol etx_protocol_i (
      .tx_lclk_par(tx_lclk_par), .arst_n(arst_n),
      .tx_access(tx_access), .tx_trans(tx_trans), .tx_ack(tx_ack),
      .frame_par(frame_par), .data_par(data_par)
   );

   etx_io etx_io_i (
      .tx_lclk_par(tx_lclk_par), .arst_n(arst_n),
      .frame_par(frame_par), .data_par(data_par),
      .ecfg_tx_enable(ecfg_tx_enable), .ecfg_tx_gpio_enable(ecfg_tx_gpio_enable),
      .ecfg_dataout(ecfg_dataout),
      .wr_wait_in(wr_wait_in), .rd_wait_in(rd_wait_in),
      .tx_frame_par(tx_frame_par), .tx_data_par(tx_data_par),
      .wr_wait(wr_wait), .rd_wait(rd_wait),
      .ecfg_tx_datain(ecfg_tx_datain)
   );

endmodule

`default_nettype wire

// ==== logic/etx_arbiter.sv ====
`default_nettype none

module etx_arbiter (
   input  wire             tx_lclk_par,
   input  wire             arst_n,
   // Queue heads
   input  etx_pkg::emesh_t emwr_head,      // Write request head
   input  etx_pkg::emesh_t emrq_head,      // Read request head
   input  etx_pkg::emesh_t emrr_head,      // Read response head
   input  wire             emwr_empty,
   input  wire             emrq_empty,
   input  wire             emrr_empty,
   output logic            emwr_rd_en,     // One-cycle pops
   output logic            emrq_rd_en,
   output logic            emrr_rd_en,
   // Synchronized push-back from the far end
   input  wire             wr_wait,
   input  wire             rd_wait,
   // To the formatter
   output logic            tx_access,      // Holding register full
   output etx_pkg::emesh_t tx_trans,       // Held transaction
   input  wire             tx_ack          // Formatter took it
);
   import etx_pkg::*;

   emesh_t hold_q;                         // Holding register, payload only
   emesh_t next_trans;                     // Winner of this cycle
   logic   hold_vld;                       // Holding register occupied
   logic   rr_ok;
   logic   wr_ok;
   logic   rq_ok;
   logic   load;

   // Write class is responses and writes, read class is requests
   assign rr_ok = !emrr_empty && !wr_wait;
   assign wr_ok = !emwr_empty && !wr_wait;
   assign rq_ok = !emrq_empty && !rd_wait;

   // No reload while anything is held, so an ack edge leaves one idle cycle
   assign load = !hold_vld && (rr_ok || wr_ok || rq_ok);

   // Fixed priority, response over write over request
   assign emrr_rd_en = load && rr_ok;
   assign emwr_rd_en = load && wr_ok && !rr_ok;
   assign emrq_rd_en = load && rq_ok && !rr_ok && !wr_ok;

   always_comb
   begin
      if (rr_ok)
         next_trans = emrr_head;
      else if (wr_ok)
         next_trans = emwr_head;
      else
         next_trans = emrq_head;           // Only used when rq_ok
   end

   always_ff @(posedge tx_lclk_par or negedge arst_n)
   begin
      if (!arst_n)
         hold_vld <= 1'b0;
      else if (load)
         hold_vld <= 1'b1;                 // Pop and capture together
      else if (tx_ack)
         hold_vld <= 1'b0;                 // Transfer done
   end

   always_ff @(posedge tx_lclk_par)
   begin
      if (load)
         hold_q <= next_trans;
   end

   assign tx_access = hold_vld;
   assign tx_trans  = hold_q;

   // Only one queue is popped per cycle
   a_one_pop: assert property (@(posedge tx_lclk_par) disable iff (!arst_n)
      $onehot0({emwr_rd_en, emrq_rd_en, emrr_rd_en}));

   // Held word must not move until the formatter acknowledges it
   a_trans_stable: assert property (@(posedge tx_lclk_par) disable iff (!arst_n)
      tx_access && !tx_ack |=> $stable(tx_trans) && tx_access);

endmodule

`default_nettype wire

// ==== logic/etx_fifo.sv ====
`default_nettype none

module etx_fifo #(
   parameter int DEPTH = 16                // Must be a power of two
) (
   input  wire             clk,
   input  wire             arst_n,
   input  wire             wr_en,          // Write strobe
   input  etx_pkg::emesh_t wr_data,        // Word to store
   input  wire             rd_en,          // Pop strobe, only when not empty
   output etx_pkg::emesh_t rd_data,        // Head word, show-ahead
   output logic            empty,
   output logic            full,
   output logic            prog_full
);
   import etx_pkg::*;

   emesh_t                     mem [DEPTH]; // Storage, no reset
   logic [$clog2(DEPTH)-1:0]   wr_ptr;      // Next slot to write
   logic [$clog2(DEPTH)-1:0]   rd_ptr;      // Current head slot
   logic [$clog2(DEPTH):0]     count;       // Occupancy, 0 to DEPTH
   logic                       do_wr;
   logic                       do_rd;

   assign do_wr = wr_en && !full;          // Write while full is dropped
   assign do_rd = rd_en && !empty;

   // Pointers wrap on their own since DEPTH is a power of two
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_wr && !do_rd)
            count <= count + 1'b1;         // Grow
         else if (do_rd && !do_wr)
            count <= count - 1'b1;         // Shrink
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
   end

   assign rd_data   = mem[rd_ptr];         // Head visible right after the write edge
   assign empty     = (count == 0);
   assign full      = (count == DEPTH);
   assign prog_full = (count >= DEPTH - prog_margin_c); // Few free entries left

   // Arbiter must never pop an empty queue
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
      rd_en |-> !empty);

   // Occupancy stays in range across any write and pop mix
   a_count_range: assert property (@(posedge clk) disable iff (!arst_n)
      count <= DEPTH);

endmodule

`default_nettype wire

// ==== logic/etx_io.sv ====
`default_nettype none

module etx_io (
   input  wire            tx_lclk_par,
   input  wire            arst_n,
   input  wire [7:0]      frame_par,       // From the formatter
   input  etx_pkg::beat_u data_par,
   input  wire            ecfg_tx_enable,  // Output enable
   input  wire            ecfg_tx_gpio_enable, // Fixed pattern mode
   input  wire [8:0]      ecfg_dataout,    // Bit 8 frame, bits 7:0 data byte
   input  wire            wr_wait_in,      // Asynchronous push-back
   input  wire            rd_wait_in,
   output logic [7:0]     tx_frame_par,
   output logic [63:0]    tx_data_par,
   output logic           wr_wait,         // Synchronized levels
   output logic           rd_wait,
   output logic [1:0]     ecfg_tx_datain   // {wr_wait, rd_wait}
);

   logic [1:0] wr_sync;                    // Two-flop chains
   logic [1:0] rd_sync;

   always_ff @(posedge tx_lclk_par or negedge arst_n)
   begin
      if (!arst_n)
      begin
         tx_frame_par <= '0;
         tx_data_par  <= '0;
      end
      else if (!ecfg_tx_enable)
      begin
         tx_frame_par <= '0;               // Line quiet when disabled
         tx_data_par  <= '0;
      end
      else if (ecfg_tx_gpio_enable)
      begin
         tx_frame_par <= {8{ecfg_dataout[8]}};    // Static pattern
         tx_data_par  <= {8{ecfg_dataout[7:0]}};  // Same byte in every lane
      end
      else
      begin
         tx_frame_par <= frame_par;
         tx_data_par  <= data_par;
      end
   end

   always_ff @(posedge tx_lclk_par or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_sync <= '0;
         rd_sync <= '0;
      end
      else
      begin
         wr_sync <= {wr_sync[0], wr_wait_in};
         rd_sync <= {rd_sync[0], rd_wait_in};
      end
   end

   assign wr_wait        = wr_sync[1];
   assign rd_wait        = rd_sync[1];
   assign ecfg_tx_datain = {wr_sync[1], rd_sync[1]}; // Status readback

endmodule

`default_nettype wire

// ==== logic/etx_pkg.sv ====
`default_nettype none

package etx_pkg;

   // Mesh transaction as it sits in a queue, MSB first
   typedef struct packed {
      logic        access;                 // Transaction valid marker
      logic        write;                  // 1 for write, 0 for read
      logic [1:0]  datamode;               // Transfer size code
      logic [3:0]  ctrlmode;               // Routing and special modes
      logic [31:0] dstaddr;                // Target address
      logic [31:0] data;                   // Write data or response data
      logic [31:0] srcaddr;                // Return address for reads
   } emesh_t;

   // Header beat, ctrl byte first on the line
   typedef struct packed {
      logic [3:0]  ctrlmode;               // Ctrl byte bits 7:4
      logic [1:0]  datamode;               // Ctrl byte bits 3:2
      logic        write;                  // Ctrl byte bit 1
      logic        pad;                    // Ctrl byte bit 0, always zero
      logic [23:0] rsvd;                   // Reserved, sent as zero
      logic [31:0] dstaddr;                // Destination address
   } beat_hdr_t;

   // Payload beat, second half of the packet
   typedef struct packed {
      logic [31:0] data;                   // Data word
      logic [31:0] srcaddr;                // Source address
   } beat_pay_t;

   // One 64-bit beat, read as header or payload depending on position
   typedef union packed {
      beat_hdr_t hdr;                      // First beat of a packet
      beat_pay_t pay;                      // Second beat of a packet
   } beat_u;

   // Frame words, frame stays high for both beats
   localparam logic [7:0] frame_hdr_c  = 8'hff; // With header beat
   localparam logic [7:0] frame_pay_c  = 8'hff; // With payload beat
   localparam logic [7:0] frame_idle_c = 8'h00; // Line idle

   // Queue sizing
   localparam int queue_depth_c = 16;      // Entries per queue, power of two
   localparam int prog_margin_c = 4;       // Free entries at which prog_full rises

endpackage

`default_nettype wire

// ==== logic/etx_protocol.sv ====
`default_nettype none

module etx_protocol (
   input  wire             tx_lclk_par,
   input  wire             arst_n,
   input  wire             tx_access,      // Arbiter has a transaction
   input  etx_pkg::emesh_t tx_trans,       // Transaction to send
   output logic            tx_ack,         // One-cycle accept pulse
   output logic [7:0]      frame_par,      // Frame word per beat
   output etx_pkg::beat_u  data_par        // Packet beat
);
   import etx_pkg::*;

   logic  ack_q;                           // Header phase, doubles as ack
   logic  pay_q;                           // Payload phase
   beat_u hdr_beat;                        // Header view of tx_trans
   beat_u pay_beat;                        // Payload view of tx_trans
   beat_u pay_hold;                        // Payload kept for the second beat

   always_comb
   begin
      hdr_beat              = '0;          // Pad and reserved bits stay zero
      hdr_beat.hdr.ctrlmode = tx_trans.ctrlmode;
      hdr_beat.hdr.datamode = tx_trans.datamode;
      hdr_beat.hdr.write    = tx_trans.write;
      hdr_beat.hdr.dstaddr  = tx_trans.dstaddr;
   end

   always_comb
   begin
      pay_beat.pay.data    = tx_trans.data;
      pay_beat.pay.srcaddr = tx_trans.srcaddr;
   end

   always_ff @(posedge tx_lclk_par or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ack_q     <= 1'b0;
         pay_q     <= 1'b0;
         frame_par <= frame_idle_c;
         data_par  <= '0;
      end
      else
      begin
         ack_q <= tx_access && !ack_q && !pay_q; // Accept only when idle
         pay_q <= ack_q;
         if (ack_q)
         begin
            frame_par <= frame_hdr_c;      // First beat
            data_par  <= hdr_beat;
         end
         else if (pay_q)
         begin
            frame_par <= frame_pay_c;      // Second beat
            data_par  <= pay_hold;
         end
         else
         begin
            frame_par <= frame_idle_c;     // Nothing on the line
            data_par  <= '0;
         end
      end
   end

   // Arbiter releases the word at this edge, keep the payload half
   always_ff @(posedge tx_lclk_par)
   begin
      if (ack_q)
         pay_hold <= pay_beat;
   end

   assign tx_ack = ack_q;

   // Ack is a single pulse, never back to back
   a_ack_pulse: assert property (@(posedge tx_lclk_par) disable iff (!arst_n)
      tx_ack |=> !tx_ack);

   // Ack only while the arbiter still presents a transaction
   a_ack_access: assert property (@(posedge tx_lclk_par) disable iff (!arst_n)
      tx_ack |-> tx_access);

endmodule

`default_nettype wire

// ==== sim.f ====
logic/etx_pkg.sv
logic/etx_fifo.sv
logic/etx_arbiter.sv
logic/etx_protocol.sv
logic/etx_io.sv
logic/etx.sv
bench/etx_tb.sv
